// File: verilog/mul_accel_pkg.sv
/*
 * Multiplier accelerator shared definitions
 * Data widths, CSR map and streamer states
 */
package mul_accel_pkg;

  // ------------------------------
  // Data types
  // ------------------------------
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [15:0] operand_t;
  typedef logic [3:0]  shift_t;

  // Streamer sequencing, one element at a time
  typedef enum logic [2:0] {IDLE, RD_A, WT_A, RD_B, WT_B, FEED, DRAIN, WR_C} stream_state_e;

  // ------------------------------
  // Accelerator CSR window
  // ------------------------------
  // Relative to the streamer offset
  localparam addr_t CsrShift  = 32'd0;
  localparam addr_t CsrCommit = 32'd1;
  localparam addr_t CsrCount  = 32'd2;

  // Streamer registers
  localparam addr_t CsrBaseA  = 32'd0;
  localparam addr_t CsrBaseB  = 32'd1;
  localparam addr_t CsrBaseC  = 32'd2;
  localparam addr_t CsrLength = 32'd3;
  localparam addr_t CsrStart  = 32'd4;
  localparam addr_t CsrStatus = 32'd5;

endpackage

// File: verilog/csr_addr_demux.sv
/*
 * CSR address demux
 * Low addresses go to the streamer, the rest to the CSR manager
 * Single outstanding request, response taken from the chosen side
 */
module csr_addr_demux import mul_accel_pkg::*; #(
  parameter int unsigned StreamerCsrNum = 6
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Upstream CSR bus
  input  addr_t csr_req_addr_i,
  input  word_t csr_req_data_i,
  input  logic  csr_req_write_i,
  input  logic  csr_req_valid_i,
  output logic  csr_req_ready_o,
  output word_t csr_rsp_data_o,
  output logic  csr_rsp_valid_o,
  input  logic  csr_rsp_ready_i,
  // Streamer side
  output addr_t s_req_addr_o,
  output word_t s_req_data_o,
  output logic  s_req_write_o,
  output logic  s_req_valid_o,
  input  logic  s_req_ready_i,
  input  word_t s_rsp_data_i,
  input  logic  s_rsp_valid_i,
  output logic  s_rsp_ready_o,
  // Manager side
  output addr_t m_req_addr_o,
  output word_t m_req_data_o,
  output logic  m_req_write_o,
  output logic  m_req_valid_o,
  input  logic  m_req_ready_i,
  input  word_t m_rsp_data_i,
  input  logic  m_rsp_valid_i,
  output logic  m_rsp_ready_o
);

  logic busy_q;
  // High when the pending request went to the streamer
  logic tgt_s_q;
  logic sel_s;
  logic req_fire;
  logic rsp_fire;

  assign sel_s = csr_req_addr_i < addr_t'(StreamerCsrNum);

  // Request fan-out, held off while a response is pending
  assign s_req_addr_o  = csr_req_addr_i;
  assign s_req_data_o  = csr_req_data_i;
  assign s_req_write_o = csr_req_write_i;
  assign s_req_valid_o = csr_req_valid_i && !busy_q && sel_s;

  // Manager sees addresses relative to its own window
  assign m_req_addr_o  = csr_req_addr_i - addr_t'(StreamerCsrNum);
  assign m_req_data_o  = csr_req_data_i;
  assign m_req_write_o = csr_req_write_i;
  assign m_req_valid_o = csr_req_valid_i && !busy_q && !sel_s;

  assign csr_req_ready_o = !busy_q && (sel_s ? s_req_ready_i : m_req_ready_i);

  // Response merge from the registered target
  assign csr_rsp_valid_o = busy_q && (tgt_s_q ? s_rsp_valid_i : m_rsp_valid_i);
  assign csr_rsp_data_o  = tgt_s_q ? s_rsp_data_i : m_rsp_data_i;
  assign s_rsp_ready_o   = busy_q && tgt_s_q && csr_rsp_ready_i;
  assign m_rsp_ready_o   = busy_q && !tgt_s_q && csr_rsp_ready_i;

  assign req_fire = csr_req_valid_i && csr_req_ready_o;
  assign rsp_fire = csr_rsp_valid_o && csr_rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      tgt_s_q <= 1'b0;
    end else if (req_fire) begin
      busy_q  <= 1'b1;
      tgt_s_q <= sel_s;
    end else if (rsp_fire) begin
      busy_q  <= 1'b0;
    end
  end

  // Responses only come from the side holding the pending request
  a_rsp_from_target : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (s_rsp_valid_i || m_rsp_valid_i) |->
      busy_q && (tgt_s_q ? !m_rsp_valid_i : !s_rsp_valid_i));

endmodule

// File: verilog/accel_csr_manager.sv
/*
 * Accelerator CSR manager
 * Holds the shift setting, commits it to the core on request
 * and reads back the live product count
 */
module accel_csr_manager import mul_accel_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  // CSR request and response
  input  addr_t  req_addr_i,
  input  word_t  req_data_i,
  input  logic   req_write_i,
  input  logic   req_valid_i,
  output logic   req_ready_o,
  output word_t  rsp_data_o,
  output logic   rsp_valid_o,
  input  logic   rsp_ready_i,
  // Configuration commit to the core
  output shift_t cfg_shift_o,
  output logic   cfg_valid_o,
  input  logic   cfg_ready_i,
  // Status from the core
  input  word_t  count_i
);

  shift_t shift_q;
  shift_t cfg_shift_q;
  logic   cfg_valid_q;
  logic   rsp_valid_q;
  word_t  rsp_data_q;
  logic   req_fire;
  logic   commit_wr;

  assign req_ready_o = !rsp_valid_q;
  assign req_fire    = req_valid_i && req_ready_o;
  assign commit_wr   = req_fire && req_write_i && (req_addr_i == CsrCommit);

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_data_q;
  assign cfg_valid_o = cfg_valid_q;
  assign cfg_shift_o = cfg_shift_q;

  // ------------------------------
  // Register file and response
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shift_q     <= '0;
      rsp_valid_q <= 1'b0;
      rsp_data_q  <= '0;
    end else begin
      if (rsp_valid_q && rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      if (req_fire) begin
        rsp_valid_q <= 1'b1;
        // Writes answer with zero
        rsp_data_q  <= '0;
        if (req_write_i) begin
          if (req_addr_i == CsrShift) begin
            shift_q <= req_data_i[3:0];
          end
        end else begin
          case (req_addr_i)
            CsrShift: rsp_data_q <= word_t'(shift_q);
            CsrCount: rsp_data_q <= count_i;
            default:  rsp_data_q <= '0;
          endcase
        end
      end
    end
  end

  // ------------------------------
  // Commit handshake
  // ------------------------------
  // Offered shift stays frozen until the core takes it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_valid_q <= 1'b0;
      cfg_shift_q <= '0;
    end else begin
      if (cfg_valid_q && cfg_ready_i) begin
        cfg_valid_q <= 1'b0;
      end
      if (commit_wr && (!cfg_valid_q || cfg_ready_i)) begin
        cfg_valid_q <= 1'b1;
        cfg_shift_q <= shift_q;
      end
    end
  end

endmodule

// File: verilog/mul_core.sv
/*
 * Two-stage multiply and shift core
 * Stage one multiplies, stage two shifts, whole pipe stalls on back-pressure
 */
module mul_core import mul_accel_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Configuration
  input  shift_t   cfg_shift_i,
  input  logic     cfg_valid_i,
  output logic     cfg_ready_o,
  // Operand stream
  input  operand_t op_a_i,
  input  operand_t op_b_i,
  input  logic     op_valid_i,
  output logic     op_ready_o,
  // Result stream
  output word_t    res_data_o,
  output logic     res_valid_o,
  input  logic     res_ready_i,
  // Delivered results since reset
  output word_t    count_o
);

  shift_t shift_q;
  logic   s1_valid_q;
  logic   s2_valid_q;
  word_t  prod_q;
  word_t  res_q;
  word_t  count_q;
  logic   stall;

  // Output stage full and not drained
  assign stall       = s2_valid_q && !res_ready_i;
  assign op_ready_o  = !stall;
  // New shift only with an empty pipeline
  assign cfg_ready_o = !s1_valid_q && !s2_valid_q;

  assign res_data_o  = res_q;
  assign res_valid_o = s2_valid_q;
  assign count_o     = count_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      shift_q    <= '0;
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      count_q    <= '0;
    end else begin
      if (cfg_valid_i && cfg_ready_o) begin
        shift_q <= cfg_shift_i;
      end
      if (!stall) begin
        s1_valid_q <= op_valid_i;
        s2_valid_q <= s1_valid_q;
      end
      if (res_valid_o && res_ready_i) begin
        count_q <= count_q + 32'd1;
      end
    end
  end

  // Datapath registers
  always_ff @(posedge clk_i) begin
    if (!stall) begin
      prod_q <= word_t'(op_a_i) * word_t'(op_b_i);
      res_q  <= prod_q >> shift_q;
    end
  end

  // Upstream holds the operands until they are taken
  a_op_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    op_valid_i && !op_ready_o |=> op_valid_i && $stable(op_a_i) && $stable(op_b_i));

endmodule

// File: verilog/tcdm_streamer.sv
/*
 * TCDM streamer
 * Run registers plus an FSM that fetches A[i] and B[i], feeds the core
 * and stores the result to C[i] over one memory port
 */
module tcdm_streamer import mul_accel_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // CSR request and response
  input  addr_t    req_addr_i,
  input  word_t    req_data_i,
  input  logic     req_write_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output word_t    rsp_data_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  // Operands to the core
  output operand_t op_a_o,
  output operand_t op_b_o,
  output logic     op_valid_o,
  input  logic     op_ready_i,
  // Results from the core
  input  word_t    res_data_i,
  input  logic     res_valid_i,
  output logic     res_ready_o,
  // TCDM port
  output addr_t    tcdm_addr_o,
  output word_t    tcdm_wdata_o,
  output logic     tcdm_write_o,
  output logic     tcdm_req_o,
  input  logic     tcdm_gnt_i,
  input  word_t    tcdm_rdata_i,
  input  logic     tcdm_rvalid_i
);

  stream_state_e state_q;
  addr_t    base_a_q;
  addr_t    base_b_q;
  addr_t    base_c_q;
  word_t    len_q;
  word_t    idx_q;
  operand_t a_q;
  operand_t b_q;
  word_t    c_q;
  logic     rsp_valid_q;
  word_t    rsp_data_q;
  logic     busy;
  logic     req_fire;
  logic     cfg_wr;

  assign busy        = state_q != IDLE;
  assign req_ready_o = !rsp_valid_q;
  assign req_fire    = req_valid_i && req_ready_o;
  // Run registers are frozen while busy
  assign cfg_wr      = req_fire && req_write_i && !busy;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = rsp_data_q;

  // ------------------------------
  // CSR access
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      base_a_q    <= '0;
      base_b_q    <= '0;
      base_c_q    <= '0;
      len_q       <= '0;
      rsp_valid_q <= 1'b0;
      rsp_data_q  <= '0;
    end else begin
      if (rsp_valid_q && rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      if (req_fire) begin
        rsp_valid_q <= 1'b1;
        rsp_data_q  <= '0;
        if (!req_write_i) begin
          case (req_addr_i)
            CsrBaseA:  rsp_data_q <= base_a_q;
            CsrBaseB:  rsp_data_q <= base_b_q;
            CsrBaseC:  rsp_data_q <= base_c_q;
            CsrLength: rsp_data_q <= len_q;
            CsrStatus: rsp_data_q <= word_t'(busy);
            default:   rsp_data_q <= '0;
          endcase
        end
      end
      if (cfg_wr) begin
        case (req_addr_i)
          CsrBaseA:  base_a_q <= req_data_i;
          CsrBaseB:  base_b_q <= req_data_i;
          CsrBaseC:  base_c_q <= req_data_i;
          CsrLength: len_q    <= req_data_i;
          default:   ;
        endcase
      end
    end
  end

  // ------------------------------
  // Element sequencer
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        // Zero length never leaves idle
        IDLE: if (cfg_wr && req_addr_i == CsrStart && len_q != '0) begin
          idx_q   <= '0;
          state_q <= RD_A;
        end
        RD_A: if (tcdm_gnt_i) state_q <= WT_A;
        WT_A: if (tcdm_rvalid_i) state_q <= RD_B;
        RD_B: if (tcdm_gnt_i) state_q <= WT_B;
        WT_B: if (tcdm_rvalid_i) state_q <= FEED;
        FEED: if (op_ready_i) state_q <= DRAIN;
        DRAIN: if (res_valid_i) state_q <= WR_C;
        WR_C: if (tcdm_gnt_i) begin
          idx_q   <= idx_q + 32'd1;
          state_q <= (idx_q + 32'd1 == len_q) ? IDLE : RD_A;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Operand and result holding registers
  always_ff @(posedge clk_i) begin
    if (state_q == WT_A && tcdm_rvalid_i) a_q <= tcdm_rdata_i[15:0];
    if (state_q == WT_B && tcdm_rvalid_i) b_q <= tcdm_rdata_i[15:0];
    if (state_q == DRAIN && res_valid_i) c_q <= res_data_i;
  end

  assign op_a_o      = a_q;
  assign op_b_o      = b_q;
  assign op_valid_o  = state_q == FEED;
  assign res_ready_o = state_q == DRAIN;

  // Word addresses, one element per word
  assign tcdm_req_o   = (state_q == RD_A) || (state_q == RD_B) || (state_q == WR_C);
  assign tcdm_write_o = state_q == WR_C;
  assign tcdm_wdata_o = c_q;
  always_comb begin
    case (state_q)
      RD_B:    tcdm_addr_o = base_b_q + idx_q;
      WR_C:    tcdm_addr_o = base_c_q + idx_q;
      default: tcdm_addr_o = base_a_q + idx_q;
    endcase
  end

  // A request waiting for its grant keeps address and data
  a_req_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tcdm_req_o && !tcdm_gnt_i |=> tcdm_req_o && $stable(tcdm_addr_o)
      && $stable(tcdm_write_o) && $stable(tcdm_wdata_o));

endmodule

// File: verilog/mul_accel_top.sv
/*
 * Streaming elementwise multiplier accelerator
 * CSR demux and manager, multiply core and TCDM streamer
 */
module mul_accel_top import mul_accel_pkg::*; #(
  parameter int unsigned StreamerCsrNum = 6
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // CSR bus
  input  addr_t csr_req_addr_i,
  input  word_t csr_req_data_i,
  input  logic  csr_req_write_i,
  input  logic  csr_req_valid_i,
  output logic  csr_req_ready_o,
  output word_t csr_rsp_data_o,
  output logic  csr_rsp_valid_o,
  input  logic  csr_rsp_ready_i,
  // TCDM port
  output addr_t tcdm_addr_o,
  output word_t tcdm_wdata_o,
  output logic  tcdm_write_o,
  output logic  tcdm_req_o,
  input  logic  tcdm_gnt_i,
  input  word_t tcdm_rdata_i,
  input  logic  tcdm_rvalid_i
);

  // Streamer CSR channel
  addr_t s_req_addr;
  word_t s_req_data;
  logic  s_req_write;
  logic  s_req_valid;
  logic  s_req_ready;
  word_t s_rsp_data;
  logic  s_rsp_valid;
  logic  s_rsp_ready;
  // Manager CSR channel
  addr_t m_req_addr;
  word_t m_req_data;
  logic  m_req_write;
  logic  m_req_valid;
  logic  m_req_ready;
  word_t m_rsp_data;
  logic  m_rsp_valid;
  logic  m_rsp_ready;
  // Core configuration and status
  shift_t cfg_shift;
  logic   cfg_valid;
  logic   cfg_ready;
  word_t  count;
  // Data streams
  operand_t op_a;
  operand_t op_b;
  logic     op_valid;
  logic     op_ready;
  word_t    res_data;
  logic     res_valid;
  logic     res_ready;

  // ------------------------------
  // Input side
  // ------------------------------
  csr_addr_demux #(
    .StreamerCsrNum  ( StreamerCsrNum  )
  ) i_csr_addr_demux (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .csr_req_addr_i  ( csr_req_addr_i  ),
    .csr_req_data_i  ( csr_req_data_i  ),
    .csr_req_write_i ( csr_req_write_i ),
    .csr_req_valid_i ( csr_req_valid_i ),
    .csr_req_ready_o ( csr_req_ready_o ),
    .csr_rsp_data_o  ( csr_rsp_data_o  ),
    .csr_rsp_valid_o ( csr_rsp_valid_o ),
    .csr_rsp_ready_i ( csr_rsp_ready_i ),
    .s_req_addr_o    ( s_req_addr      ),
    .s_req_data_o    ( s_req_data      ),
    .s_req_write_o   ( s_req_write     ),
    .s_req_valid_o   ( s_req_valid     ),
    .s_req_ready_i   ( s_req_ready     ),
    .s_rsp_data_i    ( s_rsp_data      ),
    .s_rsp_valid_i   ( s_rsp_valid     ),
    .s_rsp_ready_o   ( s_rsp_ready     ),
    .m_req_addr_o    ( m_req_addr      ),
    .m_req_data_o    ( m_req_data      ),
    .m_req_write_o   ( m_req_write     ),
    .m_req_valid_o   ( m_req_valid     ),
    .m_req_ready_i   ( m_req_ready     ),
    .m_rsp_data_i    ( m_rsp_data      ),
    .m_rsp_valid_i   ( m_rsp_valid     ),
    .m_rsp_ready_o   ( m_rsp_ready     )
  );

  accel_csr_manager i_accel_csr_manager (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_addr_i  ( m_req_addr  ),
    .req_data_i  ( m_req_data  ),
    .req_write_i ( m_req_write ),
    .req_valid_i ( m_req_valid ),
    .req_ready_o ( m_req_ready ),
    .rsp_data_o  ( m_rsp_data  ),
    .rsp_valid_o ( m_rsp_valid ),
    .rsp_ready_i ( m_rsp_ready ),
    .cfg_shift_o ( cfg_shift   ),
    .cfg_valid_o ( cfg_valid   ),
    .cfg_ready_i ( cfg_ready   ),
    .count_i     ( count       )
  );

  // ------------------------------
  // Processing
  // ------------------------------
  mul_core i_mul_core (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .cfg_shift_i ( cfg_shift ),
    .cfg_valid_i ( cfg_valid ),
    .cfg_ready_o ( cfg_ready ),
    .op_a_i      ( op_a      ),
    .op_b_i      ( op_b      ),
    .op_valid_i  ( op_valid  ),
    .op_ready_o  ( op_ready  ),
    .res_data_o  ( res_data  ),
    .res_valid_o ( res_valid ),
    .res_ready_i ( res_ready ),
    .count_o     ( count     )
  );

  // ------------------------------
  // Output side
  // ------------------------------
  tcdm_streamer i_tcdm_streamer (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .req_addr_i    ( s_req_addr    ),
    .req_data_i    ( s_req_data    ),
    .req_write_i   ( s_req_write   ),
    .req_valid_i   ( s_req_valid   ),
    .req_ready_o   ( s_req_ready   ),
    .rsp_data_o    ( s_rsp_data    ),
    .rsp_valid_o   ( s_rsp_valid   ),
    .rsp_ready_i   ( s_rsp_ready   ),
    .op_a_o        ( op_a          ),
    .op_b_o        ( op_b          ),
    .op_valid_o    ( op_valid      ),
    .op_ready_i    ( op_ready      ),
    .res_data_i    ( res_data      ),
    .res_valid_i   ( res_valid     ),
    .res_ready_o   ( res_ready     ),
    .tcdm_addr_o   ( tcdm_addr_o   ),
    .tcdm_wdata_o  ( tcdm_wdata_o  ),
    .tcdm_write_o  ( tcdm_write_o  ),
    .tcdm_req_o    ( tcdm_req_o    ),
    .tcdm_gnt_i    ( tcdm_gnt_i    ),
    .tcdm_rdata_i  ( tcdm_rdata_i  ),
    .tcdm_rvalid_i ( tcdm_rvalid_i )
  );

endmodule

// File: bench/clk_gen.sv
/*
 * Testbench clock source
 * Free-running clock, starts low
 */
module clk_gen #(
  parameter int Period = 8
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(Period / 2) clk_o = ~clk_o;

endmodule

// File: bench/mul_accel_tb.sv
/*
 * Testbench for the multiplier accelerator
 * TCDM memory model, CSR access tasks, run checks and a cycle timeout
 */
module mul_accel_tb import mul_accel_pkg::*; ();

  localparam int unsigned StreamerCsrNum = 6;
  localparam int NumRuns   = 4;
  localparam int DescWords = 5;

  // Manager registers as seen on the CSR bus
  localparam addr_t AddrShift    = addr_t'(StreamerCsrNum) + CsrShift;
  localparam addr_t AddrCommit   = addr_t'(StreamerCsrNum) + CsrCommit;
  localparam addr_t AddrCount    = addr_t'(StreamerCsrNum) + CsrCount;
  localparam addr_t AddrUnmapped = addr_t'(StreamerCsrNum) + 32'd8;

  logic  clk_i;
  logic  rst_n_i;
  addr_t csr_req_addr_i;
  word_t csr_req_data_i;
  logic  csr_req_write_i;
  logic  csr_req_valid_i;
  logic  csr_req_ready_o;
  word_t csr_rsp_data_o;
  logic  csr_rsp_valid_o;
  logic  csr_rsp_ready_i;
  addr_t tcdm_addr_o;
  word_t tcdm_wdata_o;
  logic  tcdm_write_o;
  logic  tcdm_req_o;
  logic  tcdm_gnt_i;
  word_t tcdm_rdata_i;
  logic  tcdm_rvalid_i;

  word_t      mem [256];
  logic       stall_en;
  int         cycles = 0;
  int         limit;
  // TCDM handshake seen at the last falling edge
  logic       hs_q;
  logic       hs_write_q;
  logic [7:0] hs_addr_q;
  word_t      hs_wdata_q;

  clk_gen #(.Period(8)) i_clk_gen (.clk_o(clk_i));

  mul_accel_top #(.StreamerCsrNum(StreamerCsrNum)) DUT (.*);

  // ------------------------------
  // Checks and reference model
  // ------------------------------
  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Testbench failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  function automatic word_t desc_word(input int run, input int field);
    return mem[8'(run * DescWords + field)];
  endfunction

  // Low halves multiplied as unsigned, then shifted
  function automatic word_t expected_result(input word_t a, input word_t b, input word_t shift);
    word_t prod;
    prod = {16'h0, a[15:0]} * {16'h0, b[15:0]};
    return prod >> shift[3:0];
  endfunction

  // ------------------------------
  // TCDM memory model
  // ------------------------------
  // Grant decided on the falling edge, completion one edge later
  always @(negedge clk_i) begin
    logic gnt;
    tcdm_rvalid_i = 1'b0;
    if (hs_q) begin
      if (hs_write_q) begin
        mem[hs_addr_q] = hs_wdata_q;
      end else begin
        tcdm_rdata_i  = mem[hs_addr_q];
        tcdm_rvalid_i = 1'b1;
      end
    end
    gnt        = stall_en ? ($urandom % 3 != 0) : 1'b1;
    tcdm_gnt_i = gnt;
    hs_q       = tcdm_req_o && gnt;
    hs_write_q = tcdm_write_o;
    hs_addr_q  = tcdm_addr_o[7:0];
    hs_wdata_q = tcdm_wdata_o;
    if (tcdm_req_o && tcdm_addr_o > 32'd255) begin
      $display("ERROR: TCDM request outside the 256-word memory at 0x%08h", tcdm_addr_o);
      $display("Testbench failed");
      $fatal(1, "bad TCDM address");
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("ERROR: the run did not finish within %0d cycles", limit);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------
  // CSR access
  // ------------------------------
  task automatic csr_access(input addr_t addr, input word_t wdata, input logic write,
                            output word_t rdata);
    logic taken;
    taken = 1'b0;
    @(negedge clk_i);
    csr_req_addr_i  = addr;
    csr_req_data_i  = wdata;
    csr_req_write_i = write;
    csr_req_valid_i = 1'b1;
    // Response valid means the request was taken
    do @(negedge clk_i); while (!csr_rsp_valid_o);
    csr_req_valid_i = 1'b0;
    // No new request taken while the response is pending
    check_value("csr_req_ready_o", word_t'(csr_req_ready_o), 32'h0);
    while (!taken) begin
      check_value("csr_rsp_valid_o", word_t'(csr_rsp_valid_o), 32'h1);
      taken           = stall_en ? ($urandom % 2 == 0) : 1'b1;
      csr_rsp_ready_i = taken;
      if (!taken) @(negedge clk_i);
    end
    rdata = csr_rsp_data_o;
    @(negedge clk_i);
    csr_rsp_ready_i = 1'b0;
  endtask

  task automatic csr_write(input addr_t addr, input word_t data);
    word_t rsp;
    csr_access(addr, data, 1'b1, rsp);
    // Writes answer with zero
    check_value("csr_rsp_data_o", rsp, 32'h0);
  endtask

  task automatic csr_read(input addr_t addr, output word_t data);
    csr_access(addr, 32'h0, 1'b0, data);
  endtask

  task automatic read_check(input addr_t addr, input word_t exp, input string name);
    word_t data;
    csr_read(addr, data);
    check_value(name, data, exp);
  endtask

  // ------------------------------
  // Run helpers
  // ------------------------------
  task automatic configure_run(input int run);
    csr_write(CsrBaseA, desc_word(run, 0));
    csr_write(CsrBaseB, desc_word(run, 1));
    csr_write(CsrBaseC, desc_word(run, 2));
    csr_write(CsrLength, desc_word(run, 3));
    csr_write(AddrShift, desc_word(run, 4));
    csr_write(AddrCommit, 32'h1);
  endtask

  // Poll busy until it clears
  task automatic wait_idle();
    word_t status;
    do begin
      csr_read(CsrStatus, status);
    end while (status != 32'h0);
  endtask

  task automatic check_region(input int run);
    logic [7:0] a_idx;
    logic [7:0] b_idx;
    logic [7:0] c_idx;
    int         i;
    for (i = 0; i < int'(desc_word(run, 3)); i++) begin
      a_idx = 8'(desc_word(run, 0) + word_t'(i));
      b_idx = 8'(desc_word(run, 1) + word_t'(i));
      c_idx = 8'(desc_word(run, 2) + word_t'(i));
      check_value($sformatf("mem[%02h]", c_idx), mem[c_idx],
                  expected_result(mem[a_idx], mem[b_idx], desc_word(run, 4)));
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    word_t      count_before;
    word_t      seed;
    logic [7:0] c_old;
    logic [7:0] c_new;
    int         i;
    seed            = $urandom(32'h1ec9);
    rst_n_i         = 1'b0;
    csr_req_addr_i  = '0;
    csr_req_data_i  = '0;
    csr_req_write_i = 1'b0;
    csr_req_valid_i = 1'b0;
    csr_rsp_ready_i = 1'b0;
    tcdm_gnt_i      = 1'b0;
    tcdm_rdata_i    = '0;
    tcdm_rvalid_i   = 1'b0;
    stall_en        = 1'b0;
    hs_q            = 1'b0;
    // Address-dependent fill under the loaded image
    for (i = 0; i < 256; i++) mem[8'(i)] = 32'hc0de_0000 | 32'(i);
    $readmemh("bench/mem_input.hex", mem);
    limit = 2000;
    for (i = 0; i < NumRuns; i++) limit += 40 * int'(desc_word(i, 3));
    repeat (8) @(negedge clk_i);
    // Outputs idle under reset
    check_value("csr_req_ready_o", word_t'(csr_req_ready_o), 32'h1);
    check_value("csr_rsp_valid_o", word_t'(csr_rsp_valid_o), 32'h0);
    check_value("tcdm_req_o", word_t'(tcdm_req_o), 32'h0);
    rst_n_i = 1'b1;

    // Register read-back
    csr_write(CsrBaseA, 32'h0000_1a2b);
    csr_write(CsrBaseB, 32'h0003_c4d5);
    csr_write(CsrBaseC, 32'h7e00_0011);
    csr_write(CsrLength, 32'h0000_0123);
    csr_write(AddrShift, 32'h5);
    read_check(CsrBaseA, 32'h0000_1a2b, "base_a");
    read_check(CsrBaseB, 32'h0003_c4d5, "base_b");
    read_check(CsrBaseC, 32'h7e00_0011, "base_c");
    read_check(CsrLength, 32'h0000_0123, "length");
    read_check(CsrStatus, 32'h0, "status");
    read_check(AddrShift, 32'h5, "shift");
    read_check(AddrCommit, 32'h0, "commit");
    read_check(AddrCount, 32'h0, "count");

    // Unmapped address above the manager window
    csr_write(AddrUnmapped, 32'hffff_ffff);
    read_check(AddrUnmapped, 32'h0, "unmapped");
    read_check(AddrShift, 32'h5, "shift");
    read_check(CsrBaseA, 32'h0000_1a2b, "base_a");
    read_check(AddrCount, 32'h0, "count");

    // Zero length finishes at once
    csr_write(CsrLength, 32'h0);
    csr_write(CsrStart, 32'h1);
    read_check(CsrStatus, 32'h0, "status");

    // Plain products, then a shifted run
    configure_run(0);
    csr_write(CsrStart, 32'h1);
    wait_idle();
    check_region(0);
    read_check(CsrStatus, 32'h0, "status");
    configure_run(1);
    csr_write(CsrStart, 32'h1);
    wait_idle();
    check_region(1);
    read_check(AddrCount, desc_word(0, 3) + desc_word(1, 3), "count");

    // Same run under grant and response stalls
    stall_en = 1'b1;
    configure_run(2);
    csr_write(CsrStart, 32'h1);
    wait_idle();
    stall_en = 1'b0;
    check_region(2);
    for (i = 0; i < int'(desc_word(2, 3)); i++) begin
      c_old = 8'(desc_word(1, 2) + word_t'(i));
      c_new = 8'(desc_word(2, 2) + word_t'(i));
      check_value($sformatf("mem[%02h]", c_new), mem[c_new], mem[c_old]);
    end

    // Second start while busy is dropped
    configure_run(3);
    csr_read(AddrCount, count_before);
    check_value("count", count_before, desc_word(0, 3) + desc_word(1, 3) + desc_word(2, 3));
    csr_write(CsrStart, 32'h1);
    read_check(CsrStatus, 32'h1, "status");
    csr_write(CsrStart, 32'h1);
    wait_idle();
    check_region(3);
    read_check(AddrCount, count_before + desc_word(3, 3), "count");
    read_check(CsrStatus, 32'h0, "status");

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: bench/mem_input.hex
// Descriptors from 0x00, five words per run: base A, base B, base C, length, shift
// Operand regions follow, one unsigned 16-bit value per word
@00
00000040 00000050 00000080 00000008 00000000
00000040 00000050 00000090 00000008 00000004
00000040 00000050 000000a0 00000008 00000004
00000060 00000070 000000b0 00000004 00000002
// Operand A, runs 0 to 2
@40
00000003 00000010 000000ff 00001234
0000ffff 00008000 00000001 00007fff
// Operand B, runs 0 to 2
@50
00000005 00000010 00000101 00000002
0000ffff 00000002 0000abcd 00000003
// Operand A, run 3
@60
00000064 00000200 0000fffe 00000011
// Operand B, run 3
@70
000000c8 00000040 00000003 00000011

// File: sources.f
verilog/mul_accel_pkg.sv
verilog/csr_addr_demux.sv
verilog/accel_csr_manager.sv
verilog/mul_core.sv
verilog/tcdm_streamer.sv
verilog/mul_accel_top.sv
bench/clk_gen.sv
bench/mul_accel_tb.sv

// File: Makefile
TOP = mul_accel_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
